//--- include/mpu_defines.svh
`ifndef MPU_DEFINES_SVH
`define MPU_DEFINES_SVH

// register and address widths
`define XLEN            32
`define PADDR_LEN       34
`define MPU_ENTRIES     16

// pmp cfg byte fields
`define PMPCFG_R_BIT    0
`define PMPCFG_W_BIT    1
`define PMPCFG_X_BIT    2
`define PMPCFG_A_BIT    4:3
`define PMPCFG_L_BIT    7

// pma cfg byte fields
`define PMACFG_C_BIT    0
`define PMACFG_E_BIT    1
`define PMACFG_A_BIT    4:3
`define PMACFG_L_BIT    7

// address matching modes
`define PMPCFG_A_OFF    2'd0
`define PMPCFG_A_TOR    2'd1
`define PMPCFG_A_NA4    2'd2
`define PMPCFG_A_NAPOT  2'd3

`define PMACFG_A_OFF    2'd0
`define PMACFG_A_TOR    2'd1
`define PMACFG_A_NA4    2'd2
`define PMACFG_A_NAPOT  2'd3

`define FAULT_CNT_W     8

`endif

//--- design/mpu_pkg.sv
`default_nettype none

`include "mpu_defines.svh"

package mpu_pkg;

    // one pmp or pma cfg byte
    typedef logic [7:0] cfg_t;

    // address register holding physical address bits 33:2
    typedef logic [`XLEN-1:0] addr_reg_t;

    typedef logic [`PADDR_LEN-1:0] paddr_t;

    // bits 5:4 pick the space, bits 3:0 the entry
    typedef logic [5:0] csr_sel_t;

    typedef enum logic [1:0] {
        PMPCFG,
        PMPADDR,
        PMACFG,
        PMAADDR
    } csr_space_e;

    typedef enum logic [1:0] {
        ACC_READ,
        ACC_WRITE,
        ACC_EXEC
    } acc_kind_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_RESP
    } fsm_state_e;

    typedef logic [`FAULT_CNT_W-1:0] fault_cnt_t;

endpackage

`default_nettype wire

//--- design/mpu_csr_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "mpu_defines.svh"

module mpu_csr_bank
    import mpu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             csr_we,
    input  csr_sel_t         csr_sel,
    input  logic [`XLEN-1:0] csr_wdata,
    output logic [`XLEN-1:0] csr_rdata,

    output cfg_t             pmpcfg  [`MPU_ENTRIES],
    output addr_reg_t        pmpaddr [`MPU_ENTRIES],
    output cfg_t             pmacfg  [`MPU_ENTRIES],
    output addr_reg_t        pmaaddr [`MPU_ENTRIES]
);

    csr_space_e space;
    logic [3:0] idx;
    logic [3:0] idx_next;
    logic       last_idx;

    logic       pmp_cfg_lock;
    logic       pmp_addr_lock;
    logic       pma_cfg_lock;
    logic       pma_addr_lock;

    assign space    = csr_space_e'(csr_sel[5:4]);
    assign idx      = csr_sel[3:0];
    assign idx_next = idx + 4'd1;
    assign last_idx = (idx == 4'(`MPU_ENTRIES - 1));

    // an entry is frozen by its own L bit
    assign pmp_cfg_lock = pmpcfg[idx][`PMPCFG_L_BIT];
    assign pma_cfg_lock = pmacfg[idx][`PMACFG_L_BIT];

    // address i is also the base of a locked TOR entry i+1
    assign pmp_addr_lock = pmp_cfg_lock ||
                           (!last_idx && pmpcfg[idx_next][`PMPCFG_L_BIT] &&
                            pmpcfg[idx_next][`PMPCFG_A_BIT] == `PMPCFG_A_TOR);
    assign pma_addr_lock = pma_cfg_lock ||
                           (!last_idx && pmacfg[idx_next][`PMACFG_L_BIT] &&
                            pmacfg[idx_next][`PMACFG_A_BIT] == `PMACFG_A_TOR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MPU_ENTRIES; i++) begin
                pmpcfg[i]  <= '0;
                pmpaddr[i] <= '0;
                pmacfg[i]  <= '0;
                pmaaddr[i] <= '0;
            end
        end else if (csr_we) begin
            case (space)
                PMPCFG: begin
                    if (!pmp_cfg_lock)
                        pmpcfg[idx] <= csr_wdata[7:0];
                end
                PMPADDR: begin
                    if (!pmp_addr_lock)
                        pmpaddr[idx] <= csr_wdata;
                end
                PMACFG: begin
                    if (!pma_cfg_lock)
                        pmacfg[idx] <= csr_wdata[7:0];
                end
                PMAADDR: begin
                    if (!pma_addr_lock)
                        pmaaddr[idx] <= csr_wdata;
                end
                default: ;
            endcase
        end
    end

    // cfg bytes read back zero-extended
    always_comb begin
        case (space)
            PMPCFG:  csr_rdata = {{(`XLEN - 8){1'b0}}, pmpcfg[idx]};
            PMPADDR: csr_rdata = pmpaddr[idx];
            PMACFG:  csr_rdata = {{(`XLEN - 8){1'b0}}, pmacfg[idx]};
            PMAADDR: csr_rdata = pmaaddr[idx];
            default: csr_rdata = '0;
        endcase
    end

    genvar g;
    generate
        for (g = 0; g < `MPU_ENTRIES; g++) begin : g_lock_chk
            a_pmp_locked_stable: assert property (
                @(posedge clk) disable iff (!rst_n)
                pmpcfg[g][`PMPCFG_L_BIT] |=> $stable(pmpcfg[g])
            );
            a_pma_locked_stable: assert property (
                @(posedge clk) disable iff (!rst_n)
                pmacfg[g][`PMACFG_L_BIT] |=> $stable(pmacfg[g])
            );
        end
    endgenerate

endmodule

`default_nettype wire

//--- design/mpu.sv
`timescale 1ns/10ps
`default_nettype none

`include "mpu_defines.svh"

module mpu
    import mpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  cfg_t      pmpcfg  [`MPU_ENTRIES],
    input  addr_reg_t pmpaddr [`MPU_ENTRIES],
    input  cfg_t      pmacfg  [`MPU_ENTRIES],
    input  addr_reg_t pmaaddr [`MPU_ENTRIES],
    input  paddr_t    paddr,

    output logic      pmp_v,
    output logic      pmp_l,
    output logic      pmp_x,
    output logic      pmp_w,
    output logic      pmp_r,

    output logic      pma_v,
    output logic      pma_l,
    output logic      pma_c,
    output logic      pma_e
);

    // NA4 compares the whole word and NAPOT ignores the trailing ones
    function automatic logic napot_hit(input addr_reg_t addr, input logic na4,
                                       input paddr_t pa);
        logic [`XLEN:0]   mask_tmp;
        logic [`XLEN+2:0] mask;
        paddr_t           region;
        mask_tmp  = {addr, !na4};
        mask      = {~(mask_tmp & ~(mask_tmp + 1'b1)), 2'b00};
        region    = {addr[`PADDR_LEN-3:0], 2'b00};
        napot_hit = ~|((region ^ pa) & mask[`PADDR_LEN-1:0]);
    endfunction

    function automatic logic tor_hit(input addr_reg_t base, input addr_reg_t top,
                                     input paddr_t pa);
        paddr_t lo;
        paddr_t hi;
        lo      = {base[`PADDR_LEN-3:0], 2'b00};
        hi      = {top[`PADDR_LEN-3:0], 2'b00};
        tor_hit = (lo <= pa) && (pa < hi);
    endfunction

    logic [`MPU_ENTRIES-1:0] pmp_match;
    logic [`MPU_ENTRIES-1:0] pmp_l_bits;
    logic [`MPU_ENTRIES-1:0] pmp_x_bits;
    logic [`MPU_ENTRIES-1:0] pmp_w_bits;
    logic [`MPU_ENTRIES-1:0] pmp_r_bits;

    logic [`MPU_ENTRIES-1:0] pma_match;
    logic [`MPU_ENTRIES-1:0] pma_l_bits;
    logic [`MPU_ENTRIES-1:0] pma_c_bits;
    logic [`MPU_ENTRIES-1:0] pma_e_bits;

    genvar g;
    generate
        for (g = 0; g < `MPU_ENTRIES; g++) begin : g_entry
            addr_reg_t  pmp_base;
            addr_reg_t  pma_base;
            logic [1:0] pmp_mode;
            logic [1:0] pma_mode;

            // entry 0 has an implicit base of zero
            if (g == 0) begin : g_first
                assign pmp_base = '0;
                assign pma_base = '0;
            end else begin : g_rest
                assign pmp_base = pmpaddr[g-1];
                assign pma_base = pmaaddr[g-1];
            end

            assign pmp_mode = pmpcfg[g][`PMPCFG_A_BIT];
            assign pma_mode = pmacfg[g][`PMACFG_A_BIT];

            assign pmp_match[g] =
                (pmp_mode == `PMPCFG_A_TOR && tor_hit(pmp_base, pmpaddr[g], paddr)) ||
                ((pmp_mode == `PMPCFG_A_NA4 || pmp_mode == `PMPCFG_A_NAPOT) &&
                 napot_hit(pmpaddr[g], pmp_mode == `PMPCFG_A_NA4, paddr));

            assign pma_match[g] =
                (pma_mode == `PMACFG_A_TOR && tor_hit(pma_base, pmaaddr[g], paddr)) ||
                ((pma_mode == `PMACFG_A_NA4 || pma_mode == `PMACFG_A_NAPOT) &&
                 napot_hit(pmaaddr[g], pma_mode == `PMACFG_A_NA4, paddr));

            assign pmp_l_bits[g] = pmpcfg[g][`PMPCFG_L_BIT];
            assign pmp_x_bits[g] = pmpcfg[g][`PMPCFG_X_BIT];
            assign pmp_w_bits[g] = pmpcfg[g][`PMPCFG_W_BIT];
            assign pmp_r_bits[g] = pmpcfg[g][`PMPCFG_R_BIT];

            assign pma_l_bits[g] = pmacfg[g][`PMACFG_L_BIT];
            assign pma_c_bits[g] = pmacfg[g][`PMACFG_C_BIT];
            assign pma_e_bits[g] = pmacfg[g][`PMACFG_E_BIT];
        end
    endgenerate

    // pmp permissions are ORed over all matches
    assign pmp_v = |pmp_match;
    assign pmp_l = |(pmp_match & pmp_l_bits);
    assign pmp_x = |(pmp_match & pmp_x_bits);
    assign pmp_w = |(pmp_match & pmp_w_bits);
    assign pmp_r = |(pmp_match & pmp_r_bits);

    // cacheable and executable only if every matched region agrees
    assign pma_v = |pma_match;
    assign pma_l = |(pma_match & pma_l_bits);
    assign pma_c = pma_v && !(|(pma_match & ~pma_c_bits));
    assign pma_e = pma_v && !(|(pma_match & ~pma_e_bits));

endmodule

`default_nettype wire

//--- design/mpu_access_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module mpu_access_fsm
    import mpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      req,
    input  paddr_t    req_paddr,
    input  acc_kind_e req_kind,
    input  logic      req_mmode,

    output paddr_t    paddr,
    input  logic      pmp_v,
    input  logic      pmp_l,
    input  logic      pmp_x,
    input  logic      pmp_w,
    input  logic      pmp_r,
    input  logic      pma_v,
    input  logic      pma_l,
    input  logic      pma_c,
    input  logic      pma_e,

    output logic      busy,
    output logic      resp_valid,
    output logic      resp_grant,
    output logic      resp_pmp_fault,
    output logic      resp_pma_fault,
    output logic      resp_cacheable,
    output logic      fault_inc
);

    fsm_state_e state;
    acc_kind_e  kind_q;
    logic       mmode_q;
    logic       perm;
    logic       pmp_ok;
    logic       pma_ok;

    always_comb begin
        case (kind_q)
            ACC_READ:  perm = pmp_r;
            ACC_WRITE: perm = pmp_w;
            ACC_EXEC:  perm = pmp_x;
            default:   perm = 1'b0;
        endcase
    end

    // machine mode is only checked against locked matching entries
    assign pmp_ok = mmode_q ? (!pmp_v || !pmp_l || perm) : (pmp_v && perm);
    // a pma region must match and exec needs the executable attribute
    assign pma_ok = pma_v && (kind_q != ACC_EXEC || pma_e);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:   if (req) state <= ST_LOOKUP;
                ST_LOOKUP: state <= ST_RESP;
                ST_RESP:   state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // request capture and registered decision
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            paddr   <= req_paddr;
            kind_q  <= req_kind;
            mmode_q <= req_mmode;
        end
        if (state == ST_LOOKUP) begin
            resp_grant     <= pmp_ok && pma_ok;
            resp_pmp_fault <= !pmp_ok;
            resp_pma_fault <= !pma_ok;
            resp_cacheable <= pma_c;
        end
    end

    assign busy       = (state != ST_IDLE);
    assign resp_valid = (state == ST_RESP);
    assign fault_inc  = resp_valid && !resp_grant;

    a_resp_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid |=> !resp_valid
    );

    a_grant_no_fault: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid |-> !(resp_grant && (resp_pmp_fault || resp_pma_fault))
    );

    a_busy_req_ignored: assert property (
        @(posedge clk) disable iff (!rst_n)
        (busy && req) |=> $stable(paddr)
    );

endmodule

`default_nettype wire

//--- design/mpu_fault_counter.sv
`timescale 1ns/10ps
`default_nettype none

module mpu_fault_counter
    import mpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       fault_inc,
    input  logic       fault_clr,
    output fault_cnt_t fault_cnt
);

    // clear takes priority, count holds at all ones
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fault_cnt <= '0;
        end else if (fault_clr) begin
            fault_cnt <= '0;
        end else if (fault_inc && fault_cnt != '1) begin
            fault_cnt <= fault_cnt + 1'b1;
        end
    end

    a_no_wrap: assert property (
        @(posedge clk) disable iff (!rst_n)
        (fault_cnt == '1 && !fault_clr) |=> (fault_cnt == '1)
    );

endmodule

`default_nettype wire

//--- design/mpu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mpu_defines.svh"

module mpu_top
    import mpu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,

    input  logic             csr_we,
    input  csr_sel_t         csr_sel,
    input  logic [`XLEN-1:0] csr_wdata,
    output logic [`XLEN-1:0] csr_rdata,

    input  logic             req,
    input  paddr_t           req_paddr,
    input  acc_kind_e        req_kind,
    input  logic             req_mmode,

    output logic             busy,
    output logic             resp_valid,
    output logic             resp_grant,
    output logic             resp_pmp_fault,
    output logic             resp_pma_fault,
    output logic             resp_cacheable,

    input  logic             fault_clr,
    output fault_cnt_t       fault_cnt
);

    cfg_t      pmpcfg  [`MPU_ENTRIES];
    addr_reg_t pmpaddr [`MPU_ENTRIES];
    cfg_t      pmacfg  [`MPU_ENTRIES];
    addr_reg_t pmaaddr [`MPU_ENTRIES];

    paddr_t    paddr;
    logic      pmp_v, pmp_l, pmp_x, pmp_w, pmp_r;
    logic      pma_v, pma_l, pma_c, pma_e;
    logic      fault_inc;

    mpu_csr_bank u_csr_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_we    (csr_we),
        .csr_sel   (csr_sel),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .pmpcfg    (pmpcfg),
        .pmpaddr   (pmpaddr),
        .pmacfg    (pmacfg),
        .pmaaddr   (pmaaddr)
    );

    mpu u_mpu (
        .clk     (clk),
        .rst_n   (rst_n),
        .pmpcfg  (pmpcfg),
        .pmpaddr (pmpaddr),
        .pmacfg  (pmacfg),
        .pmaaddr (pmaaddr),
        .paddr   (paddr),
        .pmp_v   (pmp_v),
        .pmp_l   (pmp_l),
        .pmp_x   (pmp_x),
        .pmp_w   (pmp_w),
        .pmp_r   (pmp_r),
        .pma_v   (pma_v),
        .pma_l   (pma_l),
        .pma_c   (pma_c),
        .pma_e   (pma_e)
    );

    mpu_access_fsm u_access_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .req_paddr      (req_paddr),
        .req_kind       (req_kind),
        .req_mmode      (req_mmode),
        .paddr          (paddr),
        .pmp_v          (pmp_v),
        .pmp_l          (pmp_l),
        .pmp_x          (pmp_x),
        .pmp_w          (pmp_w),
        .pmp_r          (pmp_r),
        .pma_v          (pma_v),
        .pma_l          (pma_l),
        .pma_c          (pma_c),
        .pma_e          (pma_e),
        .busy           (busy),
        .resp_valid     (resp_valid),
        .resp_grant     (resp_grant),
        .resp_pmp_fault (resp_pmp_fault),
        .resp_pma_fault (resp_pma_fault),
        .resp_cacheable (resp_cacheable),
        .fault_inc      (fault_inc)
    );

    mpu_fault_counter u_fault_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .fault_inc (fault_inc),
        .fault_clr (fault_clr),
        .fault_cnt (fault_cnt)
    );

endmodule

`default_nettype wire

//--- test/tb_mpu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mpu_defines.svh"

module tb_mpu_top
    import mpu_pkg::*;
();

    // rough sum of all test lengths, with a wide margin
    localparam int MAX_CYCLES = 4000;

    logic             clk;
    logic             rst_n;
    logic             csr_we;
    csr_sel_t         csr_sel;
    logic [`XLEN-1:0] csr_wdata;
    logic [`XLEN-1:0] csr_rdata;
    logic             req;
    paddr_t           req_paddr;
    acc_kind_e        req_kind;
    logic             req_mmode;
    logic             busy;
    logic             resp_valid;
    logic             resp_grant;
    logic             resp_pmp_fault;
    logic             resp_pma_fault;
    logic             resp_cacheable;
    logic             fault_clr;
    fault_cnt_t       fault_cnt;

    // mirror of the CSR contents as the core wrote them
    cfg_t      m_pmpcfg  [`MPU_ENTRIES];
    addr_reg_t m_pmpaddr [`MPU_ENTRIES];
    cfg_t      m_pmacfg  [`MPU_ENTRIES];
    addr_reg_t m_pmaaddr [`MPU_ENTRIES];

    int          exp_faults;
    int          cycle_cnt;
    logic [31:0] rng;

    mpu_top u_mpu_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .csr_we         (csr_we),
        .csr_sel        (csr_sel),
        .csr_wdata      (csr_wdata),
        .csr_rdata      (csr_rdata),
        .req            (req),
        .req_paddr      (req_paddr),
        .req_kind       (req_kind),
        .req_mmode      (req_mmode),
        .busy           (busy),
        .resp_valid     (resp_valid),
        .resp_grant     (resp_grant),
        .resp_pmp_fault (resp_pmp_fault),
        .resp_pma_fault (resp_pma_fault),
        .resp_cacheable (resp_cacheable),
        .fault_clr      (fault_clr),
        .fault_cnt      (fault_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("simulation timed out after %0d cycles", cycle_cnt);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // hit test of one entry on byte addresses widened to 64 bits
    function automatic logic region_hit(input logic [1:0] mode, input addr_reg_t addr,
                                        input addr_reg_t base, input paddr_t pa);
        logic [63:0] p;
        logic [63:0] a;
        logic [63:0] lo;
        int          t;
        p  = 64'(pa);
        a  = {30'b0, addr, 2'b00};
        lo = {30'b0, base, 2'b00};
        t  = 0;
        case (mode)
            `PMPCFG_A_TOR: region_hit = (lo <= p) && (p < a);
            `PMPCFG_A_NA4: region_hit = (p >> 2) == (a >> 2);
            `PMPCFG_A_NAPOT: begin
                // trailing ones give a region of 2^(t+3) bytes
                while (t < 32 && addr[t])
                    t++;
                region_hit = (p >> (t + 3)) == (a >> (t + 3));
            end
            default: region_hit = 1'b0;
        endcase
    endfunction

    // expected {grant, pmp fault, pma fault, cacheable}
    function automatic logic [3:0] predict(input paddr_t pa, input acc_kind_e kind,
                                           input logic mmode);
        logic      v, l, x, w, r;
        logic      pv, c_all, e_all;
        logic      perm, pmp_ok, pma_ok;
        addr_reg_t base;
        {v, l, x, w, r} = '0;
        pv    = 1'b0;
        c_all = 1'b1;
        e_all = 1'b1;
        for (int i = 0; i < `MPU_ENTRIES; i++) begin
            if (i == 0)
                base = '0;
            else
                base = m_pmpaddr[i-1];
            if (region_hit(m_pmpcfg[i][`PMPCFG_A_BIT], m_pmpaddr[i], base, pa)) begin
                v = 1'b1;
                l = l | m_pmpcfg[i][`PMPCFG_L_BIT];
                x = x | m_pmpcfg[i][`PMPCFG_X_BIT];
                w = w | m_pmpcfg[i][`PMPCFG_W_BIT];
                r = r | m_pmpcfg[i][`PMPCFG_R_BIT];
            end
            if (i == 0)
                base = '0;
            else
                base = m_pmaaddr[i-1];
            if (region_hit(m_pmacfg[i][`PMACFG_A_BIT], m_pmaaddr[i], base, pa)) begin
                pv    = 1'b1;
                c_all = c_all & m_pmacfg[i][`PMACFG_C_BIT];
                e_all = e_all & m_pmacfg[i][`PMACFG_E_BIT];
            end
        end
        perm   = (kind == ACC_READ) ? r : (kind == ACC_WRITE) ? w : x;
        pmp_ok = mmode ? (!v || !l || perm) : (v && perm);
        pma_ok = pv && (kind != ACC_EXEC || e_all);
        return {pmp_ok && pma_ok, !pmp_ok, !pma_ok, pv && c_all};
    endfunction

    function automatic logic addr_locked(input cfg_t cur, input cfg_t nxt, input logic has_nxt);
        return cur[7] || (has_nxt && nxt[7] && nxt[4:3] == `PMPCFG_A_TOR);
    endfunction

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string msg);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s (got %0h, expected %0h)", $time, msg, got, exp);
            $display("Finished with errors");
            $fatal(1, "check failed");
        end
    endtask

    task automatic csr_write(input logic [1:0] sp, input logic [3:0] idx, input logic [31:0] data);
        int   ni;
        logic has_nxt;
        ni      = (idx == 4'd15) ? 15 : idx + 1;
        has_nxt = (idx != 4'd15);
        @(negedge clk);
        csr_we    = 1'b1;
        csr_sel   = {sp, idx};
        csr_wdata = data;
        @(negedge clk);
        csr_we = 1'b0;
        // the mirror follows the lock rule
        case (sp)
            2'd0: if (!m_pmpcfg[idx][7]) m_pmpcfg[idx] = data[7:0];
            2'd1: if (!addr_locked(m_pmpcfg[idx], m_pmpcfg[ni], has_nxt)) m_pmpaddr[idx] = data;
            2'd2: if (!m_pmacfg[idx][7]) m_pmacfg[idx] = data[7:0];
            default: if (!addr_locked(m_pmacfg[idx], m_pmacfg[ni], has_nxt)) m_pmaaddr[idx] = data;
        endcase
    endtask

    task automatic csr_read(input logic [1:0] sp, input logic [3:0] idx, output logic [31:0] data);
        @(negedge clk);
        csr_sel = {sp, idx};
        #1;
        data = csr_rdata;
    endtask

    task automatic do_access(input paddr_t pa, input acc_kind_e kind, input logic mmode,
                             output logic [3:0] got);
        logic [3:0] exp;
        exp = predict(pa, kind, mmode);
        @(negedge clk);
        req       = 1'b1;
        req_paddr = pa;
        req_kind  = kind;
        req_mmode = mmode;
        @(negedge clk);
        req = 1'b0;
        check_eq(resp_valid, 0, "resp_valid one edge after req");
        check_eq(busy, 1, "busy after req");
        @(negedge clk);
        check_eq(resp_valid, 1, "resp_valid two edges after req");
        got = {resp_grant, resp_pmp_fault, resp_pma_fault, resp_cacheable};
        check_eq(got, exp, $sformatf("response for %0h kind %0d mmode %0b", pa, kind, mmode));
        if (!exp[3] && exp_faults < 255)
            exp_faults++;
        @(negedge clk);
        check_eq(resp_valid, 0, "resp_valid lasts one cycle");
        check_eq(busy, 0, "busy falls with resp_valid");
    endtask

    task automatic pulse_fault_clr();
        @(negedge clk);
        fault_clr = 1'b1;
        @(negedge clk);
        fault_clr = 1'b0;
        exp_faults = 0;
    endtask

    task automatic test_reset_state();
        logic [31:0] data;
        logic [3:0]  got;
        for (int i = 0; i < 64; i++) begin
            csr_read(i[5:4], i[3:0], data);
            check_eq(data, 0, $sformatf("csr %0d after reset", i));
        end
        check_eq(busy, 0, "busy after reset");
        check_eq(resp_valid, 0, "resp_valid after reset");
        check_eq(fault_cnt, 0, "fault_cnt after reset");
        // no pma region yet
        do_access(34'h0, ACC_READ, 1'b1, got);
        check_eq(got, 4'b0010, "machine read with no pma region");
        check_eq(fault_cnt, 1, "first fault counted");
        pulse_fault_clr();
    endtask

    task automatic test_napot_random();
        logic [3:0] got;
        paddr_t     pa;
        logic [1:0] k;
        csr_write(PMPADDR, 0, 32'h0400_0000);
        csr_write(PMPCFG, 0, 32'h13);
        csr_write(PMPADDR, 1, 32'h0800_01ff);
        csr_write(PMPCFG, 1, 32'h1d);
        csr_write(PMPADDR, 2, 32'h0800_5fff);
        csr_write(PMPCFG, 2, 32'h1a);
        // small region above 4 GiB
        csr_write(PMPADDR, 3, 32'h8000_005f);
        csr_write(PMPCFG, 3, 32'h1f);
        csr_write(PMAADDR, 0, 32'h07ff_ffff);
        csr_write(PMACFG, 0, 32'h1b);
        do_access(34'h1000_0000, ACC_WRITE, 1'b0, got);
        check_eq(got, 4'b1001, "na4 write hit");
        do_access(34'h1000_0004, ACC_READ, 1'b0, got);
        check_eq(got, 4'b0101, "na4 next word misses");
        do_access(34'h2_0000_0100, ACC_READ, 1'b0, got);
        check_eq(got, 4'b0010, "high napot without pma");
        for (int n = 0; n < 40; n++) begin
            rng = xorshift32(rng);
            case (rng[1:0])
                2'd0: pa = 34'h1000_0000;
                2'd1: pa = 34'h2000_0000;
                2'd2: pa = 34'h2001_0000;
                default: pa = 34'h2_0000_0100;
            endcase
            if (rng[31:30] != 2'd0)
                pa = pa + {rng[17:2], 2'b00};
            k = (rng[29:28] == 2'd3) ? 2'd0 : rng[29:28];
            do_access(pa, acc_kind_e'(k), 1'b0, got);
        end
    endtask

    task automatic test_tor_ranges();
        logic [3:0] got;
        for (int i = 1; i < 4; i++)
            csr_write(PMPCFG, i[3:0], 32'h0);
        csr_write(PMPADDR, 0, 32'h0000_0400);
        csr_write(PMPCFG, 0, 32'h09);
        csr_write(PMPADDR, 3, 32'h1000_0000);
        csr_write(PMPADDR, 4, 32'h1000_0800);
        csr_write(PMPCFG, 4, 32'h0b);
        // non-cacheable tor region overlapping a cacheable napot one
        csr_write(PMAADDR, 4, 32'h1000_0000);
        csr_write(PMAADDR, 5, 32'h1000_4000);
        csr_write(PMACFG, 5, 32'h0a);
        csr_write(PMAADDR, 6, 32'h1000_01ff);
        csr_write(PMACFG, 6, 32'h1b);
        do_access(34'h4000_0000, ACC_READ, 1'b0, got);
        check_eq(got, 4'b1000, "tor at base");
        do_access(34'h4000_1ffc, ACC_READ, 1'b0, got);
        check_eq(got, 4'b1000, "tor at top minus 4");
        do_access(34'h4000_2000, ACC_READ, 1'b0, got);
        check_eq(got, 4'b0100, "tor at top");
        do_access(34'h4000_0800, ACC_EXEC, 1'b0, got);
        check_eq(got, 4'b0100, "tor without x");
        do_access(34'h0, ACC_READ, 1'b0, got);
        check_eq(got, 4'b1001, "entry 0 at zero");
        do_access(34'hffc, ACC_READ, 1'b0, got);
        check_eq(got, 4'b1001, "entry 0 at top minus 4");
        do_access(34'h1000, ACC_READ, 1'b0, got);
        check_eq(got, 4'b0101, "entry 0 at top");
        do_access(34'h0, ACC_WRITE, 1'b0, got);
        check_eq(got, 4'b0101, "entry 0 without w");
    endtask

    task automatic test_lock_rules();
        logic [31:0] data;
        logic [3:0]  got;
        csr_write(PMPCFG, 4, 32'h89);
        csr_write(PMPCFG, 4, 32'h0f);
        csr_write(PMPADDR, 4, 32'h0);
        csr_write(PMPADDR, 3, 32'h0);
        csr_write(PMPADDR, 2, 32'h0000_1234);
        csr_read(PMPCFG, 4, data);
        check_eq(data, 32'h89, "locked cfg");
        csr_read(PMPADDR, 4, data);
        check_eq(data, 32'h1000_0800, "locked tor top");
        csr_read(PMPADDR, 3, data);
        check_eq(data, 32'h1000_0000, "locked tor base");
        csr_read(PMPADDR, 2, data);
        check_eq(data, 32'h0000_1234, "unlocked address");
        do_access(34'h4000_0100, ACC_WRITE, 1'b1, got);
        check_eq(got, 4'b0100, "machine write to locked read-only");
        do_access(34'h4000_0100, ACC_READ, 1'b1, got);
        check_eq(got, 4'b1000, "machine read of locked region");
        do_access(34'h100, ACC_WRITE, 1'b1, got);
        check_eq(got, 4'b1001, "machine write to unlocked region");
        do_access(34'h100, ACC_WRITE, 1'b0, got);
        check_eq(got, 4'b0101, "user write to unlocked region");
    endtask

    task automatic test_busy_timing();
        logic [3:0] got;
        do_access(34'h3000_0000, ACC_READ, 1'b1, got);
        @(negedge clk);
        req       = 1'b1;
        req_paddr = 34'h0;
        req_kind  = ACC_READ;
        req_mmode = 1'b0;
        @(negedge clk);
        // second request lands while busy
        check_eq(busy, 1, "busy before second req");
        req_paddr = 34'h3000_0000;
        @(negedge clk);
        req = 1'b0;
        check_eq(resp_valid, 1, "single response");
        got = {resp_grant, resp_pmp_fault, resp_pma_fault, resp_cacheable};
        check_eq(got, 4'b1001, "response is for the first address");
        repeat (4) begin
            @(negedge clk);
            check_eq(resp_valid, 0, "no response for ignored req");
        end
    endtask

    task automatic test_fault_count();
        logic [3:0] got;
        check_eq(fault_cnt, exp_faults, "fault count over tests");
        pulse_fault_clr();
        check_eq(fault_cnt, 0, "fault count after clear");
        do_access(34'h1000, ACC_READ, 1'b0, got);
        check_eq(got, 4'b0101, "read past entry 0 after clear");
        check_eq(fault_cnt, 1, "one fault after clear");
    endtask

    initial begin
        rst_n      = 1'b0;
        csr_we     = 1'b0;
        csr_sel    = '0;
        csr_wdata  = '0;
        req        = 1'b0;
        req_paddr  = '0;
        req_kind   = ACC_READ;
        req_mmode  = 1'b0;
        fault_clr  = 1'b0;
        exp_faults = 0;
        cycle_cnt  = 0;
        rng        = 32'h89df2d9f;
        for (int i = 0; i < `MPU_ENTRIES; i++) begin
            m_pmpcfg[i]  = '0;
            m_pmpaddr[i] = '0;
            m_pmacfg[i]  = '0;
            m_pmaaddr[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_napot_random();
        test_tor_ranges();
        test_lock_rules();
        test_busy_timing();
        test_fault_count();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- mpu_top.f
+incdir+include
design/mpu_pkg.sv
design/mpu_csr_bank.sv
design/mpu.sv
design/mpu_access_fsm.sv
design/mpu_fault_counter.sv
design/mpu_top.sv
test/tb_mpu_top.sv
